// File: hdl/texture_sampler_cfg.svh
// --------------------
// build-time sizes of the texture sampler lane
// included by the package and by modules that need raw widths
// --------------------

`ifndef TEXTURE_SAMPLER_CFG_SVH
`define TEXTURE_SAMPLER_CFG_SVH

// texel format
`define TEX_COMPONENT_NUM   3
`define TEX_DATA_WIDTH      8

// log2 of texture width and height in texels
`define TEX_ADDR_X_WIDTH    4
`define TEX_ADDR_Y_WIDTH    4

// fraction bits of the x/y coordinates
`define TEX_FRAC_WIDTH      4

// request tag
`define TEX_USER_WIDTH      8

`endif

// File: hdl/texture_sampler_pkg.sv
// --------------------
// shared types of the texture sampler lane
// imported by every block of the sampler
// --------------------

`include "texture_sampler_cfg.svh"

package texture_sampler_pkg;

    // component 0 sits in the low bits
    typedef logic [`TEX_COMPONENT_NUM-1:0][`TEX_DATA_WIDTH-1:0] texel_t;

    // signed fixed point, one integer bit more than the texel index
    typedef logic signed [`TEX_ADDR_X_WIDTH+`TEX_FRAC_WIDTH:0] coord_x_t;
    typedef logic signed [`TEX_ADDR_Y_WIDTH+`TEX_FRAC_WIDTH:0] coord_y_t;

    // texel column and row index
    typedef logic [`TEX_ADDR_X_WIDTH-1:0] addr_x_t;
    typedef logic [`TEX_ADDR_Y_WIDTH-1:0] addr_y_t;

    typedef logic [`TEX_USER_WIDTH-1:0] user_t;

    // per-axis handling of coordinates outside the texture
    typedef enum logic [1:0] {
        op_border = 2'd0,
        op_clamp  = 2'd1,
        op_mirror = 2'd2
    } border_op_e;

endpackage

// File: hdl/texture_border_unit.sv
// --------------------
// nearest texel rounding and per-axis border handling
// one register stage with valid/ready on both sides
// --------------------

`include "texture_sampler_cfg.svh"

module texture_border_unit (
    input  logic                            clk,
    input  logic                            rst,

    input  texture_sampler_pkg::addr_x_t    param_width,
    input  texture_sampler_pkg::addr_y_t    param_height,
    input  texture_sampler_pkg::border_op_e param_x_op,
    input  texture_sampler_pkg::border_op_e param_y_op,

    input  texture_sampler_pkg::user_t      s_user,
    input  texture_sampler_pkg::coord_x_t   s_x,
    input  texture_sampler_pkg::coord_y_t   s_y,
    input  logic                            s_strb,
    input  logic                            s_valid,
    output logic                            s_ready,

    output texture_sampler_pkg::user_t      m_user,
    output logic                            m_border,
    output texture_sampler_pkg::addr_x_t    m_addr_x,
    output texture_sampler_pkg::addr_y_t    m_addr_y,
    output logic                            m_strb,
    output logic                            m_valid,
    input  logic                            m_ready
);

    import texture_sampler_pkg::*;

    localparam int FRAC_W = `TEX_FRAC_WIDTH;
    localparam int X_W    = $bits(coord_x_t);
    localparam int Y_W    = $bits(coord_y_t);
    localparam int SIZE_W = (`TEX_ADDR_X_WIDTH > `TEX_ADDR_Y_WIDTH) ?
                            `TEX_ADDR_X_WIDTH : `TEX_ADDR_Y_WIDTH;
    // rounded index spans -size..size
    localparam int IDX_W  = SIZE_W + 2;
    localparam int HALF   = 1 << (FRAC_W - 1);

    typedef struct packed {
        logic              oob;
        logic [SIZE_W-1:0] addr;
    } axis_t;

    function automatic axis_t border_axis(
        input logic signed [IDX_W-1:0] idx,
        input logic [SIZE_W-1:0]       size,
        input border_op_e              op
    );
        logic signed [IDX_W-1:0] sz;
        logic signed [IDX_W-1:0] v;
        axis_t                   r;
        sz    = $signed({2'b00, size});
        v     = idx;
        r.oob = 1'b0;
        case (op)
            op_border: begin
                if (idx < 0 || idx >= sz) begin
                    r.oob = 1'b1;
                    v     = '0;
                end
            end
            op_mirror: begin
                if (idx < 0) begin
                    v = IDX_W'(-idx - 1);
                end else if (idx >= sz) begin
                    v = IDX_W'(2 * sz - 1 - idx);
                end
            end
            default: v = idx;
        endcase
        // clamp and mirror both end on the edge texel
        if (op != op_border) begin
            if (v < 0) begin
                v = '0;
            end else if (v >= sz) begin
                v = IDX_W'(sz - 1);
            end
        end
        r.addr = v[SIZE_W-1:0];
        return r;
    endfunction

    // --------------------
    // rounding to nearest
    // --------------------

    logic signed [X_W:0]     x_sum;
    logic signed [Y_W:0]     y_sum;
    logic signed [IDX_W-1:0] x_idx;
    logic signed [IDX_W-1:0] y_idx;
    axis_t                   x_res;
    axis_t                   y_res;

    assign x_sum = $signed({s_x[X_W-1], s_x}) + (X_W+1)'(HALF);
    assign y_sum = $signed({s_y[Y_W-1], s_y}) + (Y_W+1)'(HALF);
    assign x_idx = IDX_W'(x_sum >>> FRAC_W);
    assign y_idx = IDX_W'(y_sum >>> FRAC_W);

    assign x_res = border_axis(x_idx, SIZE_W'(param_width), param_x_op);
    assign y_res = border_axis(y_idx, SIZE_W'(param_height), param_y_op);

    // --------------------
    // output register
    // --------------------

    assign s_ready = !m_valid || m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            m_user   <= s_user;
            m_border <= x_res.oob || y_res.oob;
            m_addr_x <= addr_x_t'(x_res.addr);
            m_addr_y <= addr_y_t'(y_res.addr);
            m_strb   <= s_strb;
        end
    end

endmodule

// File: hdl/texture_mem_reader.sv
// --------------------
// on-chip texture memory with a load port and a stall-safe read stage
// returns blank, border or stored texel per request
// --------------------

`include "texture_sampler_cfg.svh"

module texture_mem_reader (
    input  logic                          clk,
    input  logic                          rst,

    input  texture_sampler_pkg::texel_t   param_border_value,
    input  texture_sampler_pkg::texel_t   param_blank_value,

    input  logic                          tex_we,
    input  texture_sampler_pkg::addr_x_t  tex_waddr_x,
    input  texture_sampler_pkg::addr_y_t  tex_waddr_y,
    input  texture_sampler_pkg::texel_t   tex_wdata,

    input  texture_sampler_pkg::user_t    s_user,
    input  logic                          s_border,
    input  texture_sampler_pkg::addr_x_t  s_addr_x,
    input  texture_sampler_pkg::addr_y_t  s_addr_y,
    input  logic                          s_strb,
    input  logic                          s_valid,
    output logic                          s_ready,

    output texture_sampler_pkg::user_t    m_user,
    output texture_sampler_pkg::texel_t   m_data,
    output logic                          m_strb,
    output logic                          m_valid,
    input  logic                          m_ready
);

    import texture_sampler_pkg::*;

    localparam int MEM_ADDR_W = `TEX_ADDR_Y_WIDTH + `TEX_ADDR_X_WIDTH;
    localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

    texel_t                mem [MEM_DEPTH];
    logic [MEM_ADDR_W-1:0] waddr;
    logic [MEM_ADDR_W-1:0] raddr;
    logic                  s_accept;
    texel_t                rd_texel;
    logic                  rd_border;

    // --------------------
    // texture memory
    // --------------------

    // row-major, power-of-two pitch so no multiply is needed
    assign waddr = {tex_waddr_y, tex_waddr_x};
    assign raddr = {s_addr_y, s_addr_x};

    always_ff @(posedge clk) begin
        if (tex_we) begin
            mem[waddr] <= tex_wdata;
        end
    end

    // --------------------
    // read stage
    // --------------------

    assign s_ready  = !m_valid || m_ready;
    assign s_accept = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    // read only on accept so a stalled output keeps its texel
    always_ff @(posedge clk) begin
        if (s_accept) begin
            rd_texel <= mem[raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (s_accept) begin
            m_user    <= s_user;
            rd_border <= s_border;
            m_strb    <= s_strb;
        end
    end

    // blank beats border, border beats stored data
    always_comb begin
        if (!m_strb) begin
            m_data = param_blank_value;
        end else if (rd_border) begin
            m_data = param_border_value;
        end else begin
            m_data = rd_texel;
        end
    end

endmodule

// File: hdl/texture_sampler.sv
// --------------------
// one lane of the 2D nearest texel sampler
// border unit feeds the texture memory reader, two cycles end to end
// --------------------

module texture_sampler (
    input  logic                            clk,
    input  logic                            rst,

    // configuration
    input  texture_sampler_pkg::addr_x_t    param_width,
    input  texture_sampler_pkg::addr_y_t    param_height,
    input  texture_sampler_pkg::border_op_e param_x_op,
    input  texture_sampler_pkg::border_op_e param_y_op,
    input  texture_sampler_pkg::texel_t     param_border_value,
    input  texture_sampler_pkg::texel_t     param_blank_value,

    // texture load
    input  logic                            tex_we,
    input  texture_sampler_pkg::addr_x_t    tex_waddr_x,
    input  texture_sampler_pkg::addr_y_t    tex_waddr_y,
    input  texture_sampler_pkg::texel_t     tex_wdata,

    // request
    input  texture_sampler_pkg::user_t      s_user,
    input  texture_sampler_pkg::coord_x_t   s_x,
    input  texture_sampler_pkg::coord_y_t   s_y,
    input  logic                            s_strb,
    input  logic                            s_valid,
    output logic                            s_ready,

    // response
    output texture_sampler_pkg::user_t      m_user,
    output texture_sampler_pkg::texel_t     m_data,
    output logic                            m_strb,
    output logic                            m_valid,
    input  logic                            m_ready
);

    import texture_sampler_pkg::*;

    user_t   ar_user;
    logic    ar_border;
    addr_x_t ar_addr_x;
    addr_y_t ar_addr_y;
    logic    ar_strb;
    logic    ar_valid;
    logic    ar_ready;

    texture_border_unit i_texture_border_unit (
        .clk          (clk),
        .rst          (rst),
        .param_width  (param_width),
        .param_height (param_height),
        .param_x_op   (param_x_op),
        .param_y_op   (param_y_op),
        .s_user       (s_user),
        .s_x          (s_x),
        .s_y          (s_y),
        .s_strb       (s_strb),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .m_user       (ar_user),
        .m_border     (ar_border),
        .m_addr_x     (ar_addr_x),
        .m_addr_y     (ar_addr_y),
        .m_strb       (ar_strb),
        .m_valid      (ar_valid),
        .m_ready      (ar_ready)
    );

    texture_mem_reader i_texture_mem_reader (
        .clk                (clk),
        .rst                (rst),
        .param_border_value (param_border_value),
        .param_blank_value  (param_blank_value),
        .tex_we             (tex_we),
        .tex_waddr_x        (tex_waddr_x),
        .tex_waddr_y        (tex_waddr_y),
        .tex_wdata          (tex_wdata),
        .s_user             (ar_user),
        .s_border           (ar_border),
        .s_addr_x           (ar_addr_x),
        .s_addr_y           (ar_addr_y),
        .s_strb             (ar_strb),
        .s_valid            (ar_valid),
        .s_ready            (ar_ready),
        .m_user             (m_user),
        .m_data             (m_data),
        .m_strb             (m_strb),
        .m_valid            (m_valid),
        .m_ready            (m_ready)
    );

endmodule

// File: verification/tb_texture_sampler.sv
// --------------------
// testbench of the texture sampler lane
// loads a random texture, sends random requests under back-pressure
// and checks every response against a model of the sampling rules
// --------------------

`include "texture_sampler_cfg.svh"

module tb_texture_sampler;

    timeunit 1ns;
    timeprecision 1ps;

    import texture_sampler_pkg::*;

    localparam int SEED           = 46228;
    localparam int PHASES         = 4;
    localparam int REQS_PER_PHASE = 300;
    localparam int TEX_DEPTH      = 1 << (`TEX_ADDR_Y_WIDTH + `TEX_ADDR_X_WIDTH);
    localparam int DRAIN_LIMIT    = 100;
    // 256 load cycles plus 1200 requests at up to 5 cycles, with margin
    localparam int CYCLE_LIMIT    = 10000;
    localparam int FRAC_BITS      = `TEX_FRAC_WIDTH;
    localparam int HALF_TEXEL     = 1 << (`TEX_FRAC_WIDTH - 1);

    localparam int K_IN_RANGE = 0;
    localparam int K_BORDER   = 1;
    localparam int K_CLAMP    = 2;
    localparam int K_MIRROR   = 3;
    localparam int K_BLANK    = 4;

    logic       clk = 1'b0;
    logic       rst;
    addr_x_t    param_width;
    addr_y_t    param_height;
    border_op_e param_x_op;
    border_op_e param_y_op;
    texel_t     param_border_value;
    texel_t     param_blank_value;
    logic       tex_we;
    addr_x_t    tex_waddr_x;
    addr_y_t    tex_waddr_y;
    texel_t     tex_wdata;
    user_t      s_user;
    coord_x_t   s_x;
    coord_y_t   s_y;
    logic       s_strb;
    logic       s_valid;
    logic       s_ready;
    user_t      m_user;
    texel_t     m_data;
    logic       m_strb;
    logic       m_valid;
    logic       m_ready;

    texel_t tex_model [TEX_DEPTH];
    user_t  exp_user_q [$];
    texel_t exp_data_q [$];
    logic   exp_strb_q [$];
    int     exp_kind_q [$];
    logic   req_taken = 1'b0;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     checked = 0;
    int     cycles = 0;

    texture_sampler dut_i (.*);

    always #50 clk = ~clk;

    function automatic string kind_name(input int kind);
        case (kind)
            K_IN_RANGE: return "in_range";
            K_BORDER:   return "border";
            K_CLAMP:    return "clamp";
            K_MIRROR:   return "mirror";
            default:    return "blank";
        endcase
    endfunction

    // nearest index of one axis after its border operation
    function automatic int axis_lookup(input int coord, input int size, input border_op_e op,
                                       output logic oob, output logic outside);
        int idx;
        idx     = (coord + HALF_TEXEL) >>> FRAC_BITS;
        oob     = 1'b0;
        outside = (idx < 0) || (idx >= size);
        if (op == op_border) begin
            if (outside) begin
                oob = 1'b1;
                idx = 0;
            end
        end else begin
            if (op == op_mirror && idx < 0) begin
                idx = -1 - idx;
            end else if (op == op_mirror && idx >= size) begin
                idx = 2 * size - 1 - idx;
            end
            if (idx < 0) begin
                idx = 0;
            end else if (idx >= size) begin
                idx = size - 1;
            end
        end
        return idx;
    endfunction

    task automatic model_request();
        int     xi;
        int     yi;
        logic   x_oob;
        logic   y_oob;
        logic   x_out;
        logic   y_out;
        texel_t data;
        int     kind;
        xi = axis_lookup(int'(s_x), int'(param_width), param_x_op, x_oob, x_out);
        yi = axis_lookup(int'(s_y), int'(param_height), param_y_op, y_oob, y_out);
        if (!s_strb) begin
            data = param_blank_value;
            kind = K_BLANK;
        end else if (x_oob || y_oob) begin
            data = param_border_value;
            kind = K_BORDER;
        end else begin
            data = tex_model[{addr_y_t'(yi), addr_x_t'(xi)}];
            if ((x_out && param_x_op == op_mirror) || (y_out && param_y_op == op_mirror)) begin
                kind = K_MIRROR;
            end else if (x_out || y_out) begin
                kind = K_CLAMP;
            end else begin
                kind = K_IN_RANGE;
            end
        end
        exp_user_q.push_back(s_user);
        exp_data_q.push_back(data);
        exp_strb_q.push_back(s_strb);
        exp_kind_q.push_back(kind);
    endtask

    task automatic check_response();
        string name;
        if (exp_data_q.size() == 0) begin
            $display("response with user tag %h arrived with no request outstanding", m_user);
            protocol_errors++;
        end else begin
            name = kind_name(exp_kind_q.pop_front());
            if (m_user !== exp_user_q[0]) begin
                $display("error %s user expected %h actual %h", name, exp_user_q[0], m_user);
                value_errors++;
            end
            if (m_strb !== exp_strb_q[0]) begin
                $display("error %s strb expected %b actual %b", name, exp_strb_q[0], m_strb);
                value_errors++;
            end
            if (m_data !== exp_data_q[0]) begin
                $display("error %s data expected %h actual %h", name, exp_data_q[0], m_data);
                value_errors++;
            end
            void'(exp_user_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_strb_q.pop_front());
            checked++;
        end
    endtask

    // monitor and scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            if (s_valid && s_ready) begin
                model_request();
                req_taken = 1'b1;
            end
            if (m_valid && m_ready) begin
                check_response();
            end
        end
    end

    task automatic report_counts();
        $display("%0d value errors, %0d protocol errors, %0d responses checked",
                 value_errors, protocol_errors, checked);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d responses outstanding",
                     cycles, exp_data_q.size());
            report_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic load_texture();
        for (int i = 0; i < TEX_DEPTH; i++) begin
            @(negedge clk);
            tex_we       = 1'b1;
            tex_waddr_x  = addr_x_t'(i);
            tex_waddr_y  = addr_y_t'(i >> `TEX_ADDR_X_WIDTH);
            tex_wdata    = texel_t'($urandom());
            tex_model[i] = tex_wdata;
        end
        @(negedge clk);
        tex_we = 1'b0;
    endtask

    task automatic set_phase_params();
        param_width        = addr_x_t'($urandom_range(15, 1));
        param_height       = addr_y_t'($urandom_range(15, 1));
        param_x_op         = border_op_e'($urandom_range(2, 0));
        param_y_op         = border_op_e'($urandom_range(2, 0));
        param_border_value = texel_t'($urandom());
        param_blank_value  = texel_t'($urandom());
    endtask

    // integer part from -4 to size+3, capped by the coordinate range
    function automatic int random_coord(input int size);
        int hi;
        hi = (size + 3 > 15) ? 15 : size + 3;
        return ($urandom_range(hi + 4, 0) - 4) * (1 << FRAC_BITS) +
               int'($urandom_range((1 << FRAC_BITS) - 1, 0));
    endfunction

    task automatic drive_request();
        s_user  = user_t'($urandom());
        s_x     = coord_x_t'(random_coord(int'(param_width)));
        s_y     = coord_y_t'(random_coord(int'(param_height)));
        s_strb  = ($urandom_range(99, 0) < 80);
        s_valid = 1'b1;
    endtask

    initial begin
        int sent;
        int drain;
        void'($urandom(SEED));
        rst         = 1'b1;
        tex_we      = 1'b0;
        tex_waddr_x = '0;
        tex_waddr_y = '0;
        tex_wdata   = '0;
        s_user      = '0;
        s_x         = '0;
        s_y         = '0;
        s_strb      = 1'b0;
        s_valid     = 1'b0;
        m_ready     = 1'b0;
        set_phase_params();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        load_texture();

        for (int phase = 0; phase < PHASES; phase++) begin
            set_phase_params();
            sent = 0;
            while (sent < REQS_PER_PHASE) begin
                @(negedge clk);
                m_ready = ($urandom_range(99, 0) < 70);
                if (req_taken) begin
                    req_taken = 1'b0;
                    s_valid   = 1'b0;
                    sent++;
                end
                if (!s_valid && sent < REQS_PER_PHASE && $urandom_range(9, 0) != 0) begin
                    drive_request();
                end
            end
            drain = 0;
            while (exp_data_q.size() != 0 && drain < DRAIN_LIMIT) begin
                @(negedge clk);
                m_ready = ($urandom_range(99, 0) < 70);
                drain++;
            end
            if (exp_data_q.size() != 0) begin
                $display("lost response: %0d responses never arrived in phase %0d",
                         exp_data_q.size(), phase);
                protocol_errors++;
                exp_user_q.delete();
                exp_data_q.delete();
                exp_strb_q.delete();
                exp_kind_q.delete();
            end
        end

        report_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/texture_sampler_pkg.sv
hdl/texture_border_unit.sv
hdl/texture_mem_reader.sv
hdl/texture_sampler.sv
verification/tb_texture_sampler.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the texture sampler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    -f build.f --top-module tb_texture_sampler -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
